/* logic/core_pkg.sv */
// shared definitions for the microcoded execution core
// flag bit positions, opcode classes, alu ops, width codes
// and the microword layout with its fixed micro-addresses
package core_pkg;

    localparam int FS = 7; // sign
    localparam int FZ = 6; // zero
    localparam int FH = 4; // half carry, out of bit 3
    localparam int FV = 2; // overflow
    localparam int FN = 1; // subtract
    localparam int FC = 0; // carry / borrow

    // opcode bits 7..4, classes 7 to 15 are illegal
    typedef enum logic [3:0] {
        OP_ADD = 4'd0,
        OP_SUB = 4'd1,
        OP_AND = 4'd2,
        OP_XOR = 4'd3,
        OP_DIV = 4'd4,
        OP_SCC = 4'd5,
        OP_CMP = 4'd6
    } op_class_t;

    typedef enum logic [1:0] {
        W_BYTE = 2'd0,
        W_WORD = 2'd1,
        W_QUAD = 2'd2
    } width_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_XOR,
        ALU_CMP,
        ALU_NOP
    } alu_op_t;

    typedef enum logic [1:0] {
        RES_ALU,
        RES_DIV,
        RES_CC
    } res_sel_t;

    typedef struct packed {
        alu_op_t  alu_op;
        res_sel_t res_sel;
        logic     res_we;    // write result register
        logic     flag_we;   // write flag byte
        logic     opnd_we;   // latch operands on accept
        logic     div_start;
        logic     wait_div;  // hold address while divider busy
        logic     setw;      // width from opcode bits 1..0
        logic     jsr_en;    // call completion routine
        logic     ret;
        logic     done;
        logic     illegal;
        logic     idle;      // ready for a new operation
    } ucode_word_t;

    localparam int UADDR_W = 7; // 16 classes, 8 words each

    localparam logic [UADDR_W-1:0] UA_IDLE = 7'd0;
    localparam logic [UADDR_W-1:0] UA_ILL  = 7'd112; // class 14 region
    localparam logic [UADDR_W-1:0] UA_WB   = 7'd120; // class 15 region

endpackage

/* logic/exec_if.sv */
// control bundle from the micro-sequencer to the alu and divider
// one-hot width bits and the evaluated condition ride along
`timescale 1ns/1ps

interface exec_if;

    core_pkg::alu_op_t  alu_op;
    core_pkg::res_sel_t res_sel;
    logic               res_we;
    logic               flag_we;
    logic               opnd_we;
    logic               div_start;
    logic               bs;  // byte
    logic               ws;  // word
    logic               qs;  // quad
    logic               cc;  // condition for scc

    modport ctrl (output alu_op, res_sel, res_we, flag_we, opnd_we, div_start,
                  bs, ws, qs, cc);
    modport alu  (input alu_op, res_sel, res_we, flag_we, opnd_we, bs, ws, qs, cc);
    modport div  (input opnd_we, div_start, bs, ws, qs);

endinterface

/* logic/ucode_rom.sv */
// microcode table, one routine per opcode class
// plus the shared completion routine and the illegal handler
`timescale 1ns/1ps

module ucode_rom (
    input  logic [core_pkg::UADDR_W-1:0] uaddr,
    output core_pkg::ucode_word_t        uword
);

    // execute word, always ends with a call to the completion routine
    function automatic core_pkg::ucode_word_t exec_w(
        input core_pkg::alu_op_t  op,
        input core_pkg::res_sel_t sel,
        input logic               wr
    );
        core_pkg::ucode_word_t w;
        w         = '0;
        w.alu_op  = op;
        w.res_sel = sel;
        w.res_we  = wr;
        w.flag_we = (sel != core_pkg::RES_CC); // scc keeps flags
        w.jsr_en  = 1'b1;
        return w;
    endfunction

    // class region is {class, offset}, entry at offset 1
    // offset 0 of region 0 is the reset/idle word
    always_comb begin
        uword = '0;
        case (uaddr)
            7'o000, 7'o003, 7'o013, 7'o023, 7'o033, 7'o045, 7'o053, 7'o063,
            7'o161: begin
                uword.idle    = 1'b1; // waiting for strobe
                uword.opnd_we = 1'b1;
            end
            7'o001, 7'o011, 7'o021, 7'o031, 7'o041, 7'o061: begin
                uword.setw = 1'b1; // entry, latch width
            end
            7'o051: begin
                uword.alu_op = core_pkg::ALU_NOP; // scc entry, width untouched
            end
            7'o002: uword = exec_w(core_pkg::ALU_ADD, core_pkg::RES_ALU, 1'b1);
            7'o012: uword = exec_w(core_pkg::ALU_SUB, core_pkg::RES_ALU, 1'b1);
            7'o022: uword = exec_w(core_pkg::ALU_AND, core_pkg::RES_ALU, 1'b1);
            7'o032: uword = exec_w(core_pkg::ALU_XOR, core_pkg::RES_ALU, 1'b1);
            7'o052: uword = exec_w(core_pkg::ALU_NOP, core_pkg::RES_CC, 1'b1);
            7'o062: uword = exec_w(core_pkg::ALU_CMP, core_pkg::RES_ALU, 1'b0);
            7'o042: uword.div_start = 1'b1;
            7'o043: uword.wait_div  = 1'b1; // stall here until quotient ready
            7'o044: uword = exec_w(core_pkg::ALU_NOP, core_pkg::RES_DIV, 1'b1);
            7'o160: uword.illegal = 1'b1; // falls through to 161, idle
            7'o170: begin
                uword.done = 1'b1; // completion routine
                uword.ret  = 1'b1;
            end
            default: begin
                uword.idle    = 1'b1; // stray address parks and flags it
                uword.illegal = 1'b1;
            end
        endcase
    end

endmodule

/* logic/core_ctrl.sv */
// micro-sequencer: micro-address, return register, width register
// condition evaluation and ready/done/illegal generation
`timescale 1ns/1ps

module core_ctrl (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         op_strobe,
    input  logic [7:0]                   opcode,
    input  core_pkg::ucode_word_t        uword,
    input  logic [7:0]                   flags,
    input  logic                         div_busy,
    output logic [core_pkg::UADDR_W-1:0] uaddr,
    output logic                         ready,
    output logic                         done,
    output logic                         illegal,
    exec_if.ctrl                         ex
);

    core_pkg::op_class_t          cls;
    logic [7:0]                   op_q;
    logic [core_pkg::UADDR_W-1:0] ret_q;
    logic [core_pkg::UADDR_W-1:0] nx_ua;
    logic [2:0]                   wsel;   // {qs, ws, bs}
    logic                         accept;
    logic                         still;
    logic                         bad_op;
    logic                         cc;

    assign cls    = core_pkg::op_class_t'(opcode[7:4]);
    assign bad_op = (cls > core_pkg::OP_CMP) ||
                    (cls != core_pkg::OP_SCC && opcode[1:0] == 2'd3); // no width 3
    assign ready  = uword.idle;
    assign accept = ready & op_strobe;
    assign still  = uword.idle | (uword.wait_div & div_busy);
    assign nx_ua  = {uaddr[6:3], uaddr[2:0] + 3'd1}; // stays in class region

    // 16 conditions on the flag byte, selected by opcode bits 3..0
    always_comb begin
        case (op_q[3:0])
            4'd0:  cc = 1'b0;                                           // false
            4'd1:  cc = flags[core_pkg::FS] ^ flags[core_pkg::FV];      // signed <
            4'd2:  cc = flags[core_pkg::FZ] |
                        (flags[core_pkg::FS] ^ flags[core_pkg::FV]);    // signed <=
            4'd3:  cc = flags[core_pkg::FZ] | flags[core_pkg::FC];      // unsigned <=
            4'd4:  cc = flags[core_pkg::FV];                            // overflow
            4'd5:  cc = flags[core_pkg::FS];                            // minus
            4'd6:  cc = flags[core_pkg::FZ];                            // equal
            4'd7:  cc = flags[core_pkg::FC];                            // carry
            4'd8:  cc = 1'b1;                                           // true
            4'd9:  cc = ~(flags[core_pkg::FS] ^ flags[core_pkg::FV]);   // signed >=
            4'd10: cc = ~(flags[core_pkg::FZ] |
                          (flags[core_pkg::FS] ^ flags[core_pkg::FV])); // signed >
            4'd11: cc = ~(flags[core_pkg::FZ] | flags[core_pkg::FC]);   // unsigned >
            4'd12: cc = ~flags[core_pkg::FV];
            4'd13: cc = ~flags[core_pkg::FS];
            4'd14: cc = ~flags[core_pkg::FZ];
            default: cc = ~flags[core_pkg::FC];
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            uaddr   <= core_pkg::UA_IDLE;
            ret_q   <= core_pkg::UA_IDLE;
            op_q    <= 8'd0;
            wsel    <= 3'b001; // byte
            done    <= 1'b0;
            illegal <= 1'b0;
        end else begin
            done    <= uword.done;    // one cycle after the completion word
            illegal <= uword.illegal;
            if (!still) uaddr <= nx_ua;
            if (uword.setw) begin
                case (op_q[1:0])
                    core_pkg::W_BYTE: wsel <= 3'b001;
                    core_pkg::W_WORD: wsel <= 3'b010;
                    default:          wsel <= 3'b100;
                endcase
            end
            if (uword.jsr_en) begin
                ret_q <= nx_ua; // word after the call
                uaddr <= core_pkg::UA_WB;
            end
            if (uword.ret) uaddr <= ret_q;
            if (accept) begin
                op_q  <= opcode;
                uaddr <= bad_op ? core_pkg::UA_ILL : {opcode[7:4], 3'd1};
            end
        end
    end

    assign ex.alu_op    = uword.alu_op;
    assign ex.res_sel   = uword.res_sel;
    assign ex.res_we    = uword.res_we;
    assign ex.flag_we   = uword.flag_we;
    assign ex.opnd_we   = uword.opnd_we & op_strobe; // only idle words carry it
    assign ex.div_start = uword.div_start;
    assign ex.qs        = wsel[2];
    assign ex.ws        = wsel[1];
    assign ex.bs        = wsel[0];
    assign ex.cc        = cc;

endmodule

/* logic/core_alu.sv */
// width-aware add/sub/and/xor/compare with flag generation
// holds the flag byte and the result register
`timescale 1ns/1ps

module core_alu (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] opnd_a,
    input  logic [31:0] opnd_b,
    input  logic [31:0] quotient,
    input  logic        div_zero,
    output logic [7:0]  flags,
    output logic [31:0] result,
    exec_if.alu         ex
);

    logic [31:0] a_q, b_q;
    logic [31:0] mask, am, bm;
    logic [32:0] wide;    // one bit beyond quad for carry
    logic [4:0]  half;    // nibble add/sub for H
    logic [31:0] sum, lres, alu_out;
    logic        is_sub, is_logic, cout, sa, sb, sr, ovf;
    logic [7:0]  nflags;

    function automatic logic top_bit(input logic [31:0] x, input logic q, input logic w);
        return q ? x[31] : (w ? x[15] : x[7]);
    endfunction

    assign mask = ex.bs ? 32'h0000_00ff : (ex.ws ? 32'h0000_ffff : 32'hffff_ffff);
    assign am   = a_q & mask;
    assign bm   = b_q & mask;

    assign is_sub   = (ex.alu_op == core_pkg::ALU_SUB) || (ex.alu_op == core_pkg::ALU_CMP);
    assign is_logic = (ex.alu_op == core_pkg::ALU_AND) || (ex.alu_op == core_pkg::ALU_XOR);

    assign wide = is_sub ? {1'b0, am} - {1'b0, bm} : {1'b0, am} + {1'b0, bm};
    assign half = is_sub ? {1'b0, am[3:0]} - {1'b0, bm[3:0]}
                         : {1'b0, am[3:0]} + {1'b0, bm[3:0]};
    assign sum  = wide[31:0] & mask;
    assign lres = (ex.alu_op == core_pkg::ALU_AND) ? (am & bm) : (am ^ bm);
    assign cout = ex.qs ? wide[32] : (ex.ws ? wide[16] : wide[8]); // carry or borrow

    assign sa  = top_bit(am, ex.qs, ex.ws);
    assign sb  = top_bit(bm, ex.qs, ex.ws);
    assign sr  = top_bit(sum, ex.qs, ex.ws);
    assign ovf = is_sub ? (sa != sb) && (sr != sa) : (sa == sb) && (sr != sa);

    assign alu_out = is_logic ? lres : sum;

    always_comb begin
        nflags = 8'd0; // unused bits stay clear
        if (ex.res_sel == core_pkg::RES_DIV) begin
            nflags[core_pkg::FZ] = (quotient == 32'd0);
            nflags[core_pkg::FV] = div_zero;
        end else if (is_logic) begin
            nflags[core_pkg::FS] = top_bit(lres, ex.qs, ex.ws);
            nflags[core_pkg::FZ] = (lres == 32'd0);
        end else begin
            nflags[core_pkg::FS] = sr;
            nflags[core_pkg::FZ] = (sum == 32'd0);
            nflags[core_pkg::FH] = half[4];
            nflags[core_pkg::FV] = ovf;
            nflags[core_pkg::FN] = is_sub;
            nflags[core_pkg::FC] = cout;
        end
    end

    always_ff @(posedge clk) begin
        if (ex.opnd_we) begin
            a_q <= opnd_a; // raw, masked once width is known
            b_q <= opnd_b;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flags  <= 8'd0;
            result <= 32'd0;
        end else begin
            if (ex.flag_we) flags <= nflags;
            if (ex.res_we) begin
                case (ex.res_sel)
                    core_pkg::RES_DIV: result <= quotient;
                    core_pkg::RES_CC:  result <= {31'd0, ex.cc};
                    default:           result <= alu_out;
                endcase
            end
        end
    end

endmodule

/* logic/core_div.sv */
// iterative unsigned restoring divider, one quotient bit per cycle
// zero divisor runs through and leaves an all-ones quotient
`timescale 1ns/1ps

module core_div (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] opnd_a,
    input  logic [31:0] opnd_b,
    output logic [31:0] quotient,
    output logic        div_zero,
    output logic        busy,
    exec_if.div         ex
);

    logic [31:0] a_q, b_q;
    logic [31:0] mask, dvs;
    logic [31:0] q;        // dividend shifts out the top, quotient in the bottom
    logic [31:0] rem;
    logic [32:0] shifted;
    logic [32:0] trial;
    logic        ge;
    logic [5:0]  cnt;      // steps left

    assign mask    = ex.qs ? 32'hffff_ffff : (ex.ws ? 32'h0000_ffff : 32'h0000_00ff);
    assign shifted = {rem, q[31]};
    assign ge      = shifted >= {1'b0, dvs}; // always true for a zero divisor
    assign trial   = shifted - {1'b0, dvs};

    always_ff @(posedge clk) begin
        if (ex.opnd_we) begin
            a_q <= opnd_a;
            b_q <= opnd_b;
        end
        if (ex.div_start) begin
            dvs <= b_q & mask;
            rem <= 32'd0;
            // left-align the dividend so the top bit is always q[31]
            q   <= ex.qs ? a_q : (ex.ws ? {a_q[15:0], 16'd0} : {a_q[7:0], 24'd0});
        end else if (busy) begin
            rem <= ge ? trial[31:0] : shifted[31:0];
            q   <= {q[30:0], ge};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt      <= 6'd0;
            div_zero <= 1'b0;
        end else if (ex.div_start) begin
            cnt      <= ex.qs ? 6'd32 : (ex.ws ? 6'd16 : 6'd8);
            div_zero <= ((b_q & mask) == 32'd0);
        end else if (busy) begin
            cnt <= cnt - 6'd1;
        end
    end

    assign busy     = (cnt != 6'd0);
    assign quotient = q; // upper bits already shifted to zero

endmodule

/* logic/core_top.sv */
// top level of the microcoded execution core
// sequencer, microcode rom, alu and divider joined by exec_if
`timescale 1ns/1ps

module core_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        op_strobe,
    input  logic [7:0]  opcode,
    input  logic [31:0] opnd_a,
    input  logic [31:0] opnd_b,
    output logic        ready,
    output logic        done,
    output logic        illegal,
    output logic [31:0] result,
    output logic [7:0]  flags
);

    exec_if ex ();

    logic [core_pkg::UADDR_W-1:0] uaddr;
    core_pkg::ucode_word_t        uword;
    logic [31:0]                  quotient;
    logic                         div_zero;
    logic                         div_busy;

    core_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .op_strobe (op_strobe),
        .opcode    (opcode),
        .uword     (uword),
        .flags     (flags),
        .div_busy  (div_busy),
        .uaddr     (uaddr),
        .ready     (ready),
        .done      (done),
        .illegal   (illegal),
        .ex        (ex.ctrl)
    );

    ucode_rom u_rom (
        .uaddr (uaddr),
        .uword (uword)
    );

    core_alu u_alu (
        .clk      (clk),
        .rst      (rst),
        .opnd_a   (opnd_a),
        .opnd_b   (opnd_b),
        .quotient (quotient),
        .div_zero (div_zero),
        .flags    (flags),
        .result   (result),
        .ex       (ex.alu)
    );

    core_div u_div (
        .clk      (clk),
        .rst      (rst),
        .opnd_a   (opnd_a),
        .opnd_b   (opnd_b),
        .quotient (quotient),
        .div_zero (div_zero),
        .busy     (div_busy),
        .ex       (ex.div)
    );

endmodule

/* verification/core_tb.sv */
// testbench for the microcoded execution core
// reference model, operation stimulus and completion assertions
`timescale 1ns/1ps

module core_tb;

    localparam int TIMEOUT = 200; // cycles per operation, quad div needs about 36

    logic        clk;
    logic        rst;
    logic        op_strobe;
    logic [7:0]  opcode;
    logic [31:0] opnd_a;
    logic [31:0] opnd_b;
    logic        ready;
    logic        done;
    logic        illegal;
    logic [31:0] result;
    logic [7:0]  flags;

    logic [31:0] exp_result = 32'd0; // model state, follows every issued op
    logic [7:0]  exp_flags  = 8'd0;
    logic        exp_ill    = 1'b0;
    int          errors     = 0;
    int          ops        = 0;
    int          tests      = 0;
    int          test_errs  = 0; // error count at test start
    int          test_ops   = 0;
    integer      seed       = 58316;

    core_top u_core_top (
        .clk       (clk),
        .rst       (rst),
        .op_strobe (op_strobe),
        .opcode    (opcode),
        .opnd_a    (opnd_a),
        .opnd_b    (opnd_b),
        .ready     (ready),
        .done      (done),
        .illegal   (illegal),
        .result    (result),
        .flags     (flags)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns period
    end

    // result and flags on every done or illegal pulse
    a_result: assert property (@(posedge clk) disable iff (rst)
        (done || illegal) |-> result == exp_result)
        else begin
            $display("error: result is %h, expected %h", $sampled(result), $sampled(exp_result));
            errors = errors + 1;
        end
    a_flags: assert property (@(posedge clk) disable iff (rst)
        (done || illegal) |-> flags == exp_flags)
        else begin
            $display("error: flags is %h, expected %h", $sampled(flags), $sampled(exp_flags));
            errors = errors + 1;
        end
    a_done_legal: assert property (@(posedge clk) disable iff (rst) done |-> !exp_ill)
        else begin
            $display("done pulse came for an illegal opcode %h", $sampled(opcode));
            errors = errors + 1;
        end
    a_ill_expected: assert property (@(posedge clk) disable iff (rst) illegal |-> exp_ill)
        else begin
            $display("illegal pulse came for a legal opcode %h", $sampled(opcode));
            errors = errors + 1;
        end

    // entries 8..15 are the complements of 0..7, so 8 is true
    function automatic logic cond_holds(input logic [3:0] sel, input logic [7:0] f);
        logic lt;
        logic base;
        lt = f[core_pkg::FS] ^ f[core_pkg::FV]; // signed less
        case (sel[2:0])
            3'd0:    base = 1'b0;
            3'd1:    base = lt;
            3'd2:    base = lt | f[core_pkg::FZ];
            3'd3:    base = f[core_pkg::FZ] | f[core_pkg::FC]; // unsigned <=
            3'd4:    base = f[core_pkg::FV];
            3'd5:    base = f[core_pkg::FS];
            3'd6:    base = f[core_pkg::FZ];
            default: base = f[core_pkg::FC];
        endcase
        return sel[3] ? ~base : base;
    endfunction

    // expected result and flags from the operation rules
    task automatic model_op(input logic [7:0] op, input logic [31:0] a, input logic [31:0] b);
        int          nb;
        logic [3:0]  cls;
        logic [32:0] mask;
        logic [32:0] am;
        logic [32:0] bm;
        logic [32:0] r;
        logic [7:0]  f;
        logic        sa;
        logic        sb;
        logic        sr;
        cls     = op[7:4];
        nb      = (op[1:0] == 2'd0) ? 8 : ((op[1:0] == 2'd1) ? 16 : 32);
        mask    = (33'd1 << nb) - 33'd1;
        am      = {1'b0, a} & mask;
        bm      = {1'b0, b} & mask;
        f       = 8'd0;
        exp_ill = (cls > 4'd6) || (cls != 4'd5 && op[1:0] == 2'd3);
        if (!exp_ill) begin
            case (cls)
                4'd0, 4'd1, 4'd6: begin
                    r = (cls == 4'd0) ? am + bm : am - bm; // 33 bits keeps carry/borrow
                    f[core_pkg::FC] = r[nb];
                    if (cls == 4'd0)
                        f[core_pkg::FH] = ({1'b0, am[3:0]} + {1'b0, bm[3:0]}) > 5'd15;
                    else
                        f[core_pkg::FH] = am[3:0] < bm[3:0];
                    r  = r & mask;
                    sa = am[nb-1];
                    sb = bm[nb-1];
                    sr = r[nb-1];
                    f[core_pkg::FS] = sr;
                    f[core_pkg::FZ] = (r == 33'd0);
                    f[core_pkg::FV] = (cls == 4'd0) ? (sa == sb && sr != sa)
                                                    : (sa != sb && sr != sa);
                    f[core_pkg::FN] = (cls != 4'd0);
                    exp_flags = f;
                    if (cls != 4'd6) exp_result = r[31:0]; // cmp keeps result
                end
                4'd2, 4'd3: begin
                    r = (cls == 4'd2) ? (am & bm) : (am ^ bm);
                    f[core_pkg::FS] = r[nb-1];
                    f[core_pkg::FZ] = (r == 33'd0);
                    exp_flags  = f;
                    exp_result = r[31:0];
                end
                4'd4: begin
                    if (bm == 33'd0) begin
                        r = mask; // zero divisor, all ones
                        f[core_pkg::FV] = 1'b1;
                    end else begin
                        r = am / bm;
                    end
                    f[core_pkg::FZ] = (r == 33'd0);
                    exp_flags  = f;
                    exp_result = r[31:0];
                end
                default: exp_result = {31'd0, cond_holds(op[3:0], exp_flags)}; // scc
            endcase
        end
    endtask

    // one strobe, then wait for done or illegal
    task automatic issue(input logic [7:0] op, input logic [31:0] a, input logic [31:0] b);
        int   n;
        logic got;
        @(posedge clk);
        op_strobe <= 1'b1;
        opcode    <= op;
        opnd_a    <= a;
        opnd_b    <= b;
        model_op(op, a, b);
        @(posedge clk);
        op_strobe <= 1'b0; // accepted on this edge
        n   = 0;
        got = 1'b0;
        while (!got && n < TIMEOUT) begin
            @(posedge clk);
            n = n + 1;
            if (done || illegal) begin
                got = 1'b1;
            end else begin
                assert (!ready) else begin
                    $display("ready came back before done for opcode %h", op);
                    errors = errors + 1;
                end
            end
        end
        if (!got) begin
            $display("timeout: no done or illegal within %0d cycles for opcode %h", TIMEOUT, op);
            $display("SIMULATION FAILED");
            $finish;
        end else begin
            ops      = ops + 1;
            test_ops = test_ops + 1;
            @(negedge clk); // done-edge assertions have run by now
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            $display("error: %s is %h, expected %h", name, got, exp);
            errors = errors + 1;
        end
    endtask

    task automatic end_test(input string name);
        tests = tests + 1;
        $display("test %-12s %4d operations, %0d errors", name, test_ops, errors - test_errs);
        test_errs = errors;
        test_ops  = 0;
    endtask

    initial begin
        logic [31:0] ev [5];
        logic [31:0] m;
        logic [31:0] hi;
        logic [1:0]  wc;
        rst       <= 1'b1;
        op_strobe <= 1'b0;
        opcode    <= 8'd0;
        opnd_a    <= 32'd0;
        opnd_b    <= 32'd0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        check_value("ready", {31'd0, ready}, 32'd1);
        check_value("done", {31'd0, done}, 32'd0);
        check_value("illegal", {31'd0, illegal}, 32'd0);
        check_value("result", result, 32'd0);
        check_value("flags", {24'd0, flags}, 32'd0);
        end_test("reset");

        for (int w = 0; w < 3; w++) begin
            wc    = w[1:0];
            m     = (w == 0) ? 32'h0000_00ff : ((w == 1) ? 32'h0000_ffff : 32'hffff_ffff);
            ev[0] = 32'd0;
            ev[1] = 32'd1;
            ev[2] = m >> 1;          // largest positive
            ev[3] = (m >> 1) + 32'd1; // most negative
            ev[4] = m;
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 5; j++) begin
                    hi = $random(seed) & ~m; // junk above the width
                    issue({4'd0, 2'd0, wc}, ev[i] | hi, ev[j]);
                    issue({4'd1, 2'd0, wc}, ev[i], ev[j] | hi);
                end
            end
            repeat (6) begin
                issue({4'd0, 2'd0, wc}, $random(seed), $random(seed));
                issue({4'd1, 2'd0, wc}, $random(seed), $random(seed));
                issue({4'd6, 2'd0, wc}, $random(seed), $random(seed));
            end
            issue({4'd6, 2'd0, wc}, ev[2], ev[2]); // equal compare
        end
        end_test("add_sub_cmp");

        for (int w = 0; w < 3; w++) begin
            wc = w[1:0];
            repeat (8) begin
                issue({4'd2, 2'd0, wc}, $random(seed), $random(seed));
                issue({4'd3, 2'd0, wc}, $random(seed), $random(seed));
            end
            issue({4'd2, 2'd0, wc}, $random(seed), 32'd0);
            issue({4'd3, 2'd0, wc}, 32'h5a5a_5a5a, 32'h5a5a_5a5a);
        end
        end_test("and_xor");

        // known flag states, then every condition on each
        for (int k = 0; k < 5; k++) begin
            case (k)
                0: issue(8'h60, 32'd5, 32'd5);                 // equal
                1: issue(8'h60, 32'd3, 32'd5);                 // borrow, minus
                2: issue(8'h00, 32'h7f, 32'h01);               // signed overflow
                3: issue(8'h21, 32'h1234, 32'd0);              // zero, flags clear
                default: issue(8'h12, 32'h8000_0000, 32'd1);   // quad overflow
            endcase
            for (int c = 0; c < 16; c++) issue({4'd5, c[3:0]}, $random(seed), $random(seed));
        end
        end_test("scc");

        for (int w = 0; w < 3; w++) begin
            wc = w[1:0];
            for (int k = 0; k < 6; k++) begin
                m = $random(seed);
                issue({4'd4, 2'd0, wc}, $random(seed), m >> (k * 5)); // spread divisor size
            end
            issue({4'd4, 2'd0, wc}, $random(seed), 32'd0);
            issue({4'd4, 2'd0, wc}, 32'd0, 32'd3);
        end
        end_test("div");

        for (int c = 7; c < 16; c++) issue({c[3:0], 4'd0}, $random(seed), $random(seed));
        issue(8'h03, $random(seed), $random(seed));
        issue(8'h13, $random(seed), $random(seed));
        issue(8'h23, $random(seed), $random(seed));
        issue(8'h33, $random(seed), $random(seed));
        issue(8'h43, $random(seed), $random(seed));
        issue(8'h63, $random(seed), $random(seed));
        issue(8'h02, 32'h0000_1234, 32'h0000_4321); // legal op still completes
        end_test("illegal");

        $display("tests %0d, operations %0d, errors %0d", tests, ops, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
logic/core_pkg.sv
logic/exec_if.sv
logic/ucode_rom.sv
logic/core_ctrl.sv
logic/core_alu.sv
logic/core_div.sv
logic/core_top.sv
verification/core_tb.sv

/* Bender.yml */
package:
  name: core

sources:
  - logic/core_pkg.sv
  - logic/exec_if.sv
  - logic/ucode_rom.sv
  - logic/core_ctrl.sv
  - logic/core_alu.sv
  - logic/core_div.sv
  - logic/core_top.sv
  - target: test
    files:
      - verification/core_tb.sv
